/* src/compy_pkg.sv */
`default_nettype none

package compy_pkg;

   // cpu side wishbone classic, one byte lane
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [15:0] adr;
      logic [7:0]  dat;
   } wb_req_t;

   typedef struct packed {
      logic       ack;
      logic [7:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic        req;
      logic [15:0] adr;    // full cpu-map address inside vram
   } fetch_req_t;

   typedef enum logic [4:0] {
      REG_RAM   = 5'b00001,
      REG_VREGS = 5'b00010,
      REG_VRAM  = 5'b00100,
      REG_ROM   = 5'b01000,
      REG_NONE  = 5'b10000
   } region_t;

   // address map
   localparam logic [15:0] RAM_LAST   = 16'h8FFF;
   localparam logic [15:0] VREGS_BASE = 16'h9000;
   localparam logic [15:0] VREGS_LAST = 16'h907F;
   localparam logic [15:0] VRAM_BASE  = 16'hA000;
   localparam logic [15:0] VRAM_LAST  = 16'hDFFF;
   localparam logic [15:0] ROM_BASE   = 16'hE000;

   localparam int RAM_DEPTH  = 4096;   // scaled down, wraps
   localparam int VRAM_DEPTH = 2048;
   localparam int ROM_DEPTH  = 2048;
   localparam int PAGE_BYTES = 512;

   // video register offsets
   localparam logic [7:0] VR_CTRL   = 8'h00;   // bit0 start, bits 2:1 mode
   localparam logic [7:0] VR_PAGE   = 8'h01;
   localparam logic [7:0] VR_STATUS = 8'h02;   // bit0 busy

   // bytes per scan line, indexed by mode
   localparam logic [5:0] LINE_LEN [0:3] = '{6'd16, 6'd20, 6'd32, 6'd16};

   localparam logic [7:0] ROM_XOR       = 8'h5A;
   localparam logic [7:0] UNMAPPED_DATA = 8'hFF;

endpackage

`default_nettype wire

/* src/addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_decode (
   input  logic [15:0]        adr,
   output compy_pkg::region_t region,
   output logic [15:0]        offset
);
   import compy_pkg::*;

   always_comb begin
      region = REG_NONE;
      offset = adr;                          // unmapped keeps raw address
      if (adr <= RAM_LAST) begin
         region = REG_RAM;
         offset = adr;                       // ram starts at zero
      end else if (adr >= VREGS_BASE && adr <= VREGS_LAST) begin
         region = REG_VREGS;
         offset = adr - VREGS_BASE;
      end else if (adr >= VRAM_BASE && adr <= VRAM_LAST) begin
         region = REG_VRAM;
         offset = adr - VRAM_BASE;
      end else if (adr >= ROM_BASE) begin
         region = REG_ROM;
         offset = adr - ROM_BASE;
      end
   end

endmodule

`default_nettype wire

/* src/char_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module char_rom (
   input  logic        sys_clk,
   input  logic        sel,
   input  logic [10:0] adr,
   output logic [7:0]  rdata
);
   import compy_pkg::*;

   logic [7:0] rom [ROM_DEPTH];

   // glyph data follows the fixed xor pattern
   initial begin
      for (int i = 0; i < ROM_DEPTH; i++) begin
         rom[i] = 8'(i) ^ ROM_XOR;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (sel) begin
         rdata <= rom[adr];                  // one cycle read latency
      end
   end

   a_sel_adr_known: assert property (
      @(posedge sys_clk) $rose(sel) |-> !$isunknown(adr)
   ) else $error("char_rom selected with unknown address");

endmodule

`default_nettype wire

/* src/ram_block.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_block #(
   parameter int DEPTH = 4096
) (
   input  logic        sys_clk,
   input  logic        sel,
   input  logic        we,
   input  logic [15:0] adr,
   input  logic [7:0]  wdata,
   output logic [7:0]  rdata
);

   localparam int AW = $clog2(DEPTH);

   logic [7:0]    mem [DEPTH];
   logic [AW-1:0] idx;

   assign idx = adr[AW-1:0];                 // wraps modulo depth

   always_ff @(posedge sys_clk) begin
      if (sel) begin
         if (we) begin
            mem[idx] <= wdata;
         end
         rdata <= mem[idx];                  // old data on a write cycle
      end
   end

   a_sel_known: assert property (
      @(posedge sys_clk) sel |-> !$isunknown({we, idx})
   ) else $error("ram_block access with unknown control");

endmodule

`default_nettype wire

/* src/video_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module video_regs (
   input  logic       sys_clk,
   input  logic       reset_n,
   input  logic       sel,
   input  logic       we,
   input  logic [7:0] adr,
   input  logic [7:0] wdata,
   output logic [7:0] rdata,
   input  logic       busy,
   output logic       start_pulse,
   output logic [1:0] mode,
   output logic [7:0] page
);
   import compy_pkg::*;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         mode        <= 2'd0;
         page        <= 8'd0;
         start_pulse <= 1'b0;
      end else begin
         start_pulse <= 1'b0;
         if (sel && we) begin
            case (adr)
               VR_CTRL: begin
                  mode        <= wdata[2:1];
                  start_pulse <= wdata[0] && !busy;   // dropped while a line runs
               end
               VR_PAGE: page <= wdata;
               default: ;                            // status is read only
            endcase
         end
      end
   end

   // read path, one cycle after select
   always_ff @(posedge sys_clk) begin
      if (sel) begin
         case (adr)
            VR_CTRL:   rdata <= {5'd0, mode, 1'b0};  // start reads as 0
            VR_PAGE:   rdata <= page;
            VR_STATUS: rdata <= {7'd0, busy};
            default:   rdata <= 8'h00;
         endcase
      end
   end

   a_start_single: assert property (
      @(posedge sys_clk) disable iff (!reset_n)
      start_pulse |=> !start_pulse
   ) else $error("start_pulse held for more than one cycle");

endmodule

`default_nettype wire

/* src/video_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module video_fetch (
   input  logic                  sys_clk,
   input  logic                  reset_n,
   input  logic                  start_pulse,
   input  logic [1:0]            mode,
   input  logic [7:0]            page,
   output compy_pkg::fetch_req_t freq,
   input  logic                  fetch_ack,
   input  logic [7:0]            fetch_dat,
   output logic                  busy,
   output logic [7:0]            scan_data,
   output logic                  scan_valid
);
   import compy_pkg::*;

   localparam int OFS_W = $clog2(VRAM_DEPTH);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_FETCH,
      ST_LAST
   } state_t;

   state_t           state;
   logic [OFS_W-1:0] ofs;                    // byte offset inside vram
   logic [5:0]       left;                   // bytes still to fetch
   logic             last_byte;

   assign last_byte = (left == 6'd1);
   assign busy      = (state != ST_IDLE);

   always_comb begin
      freq.req = (state == ST_FETCH);
      freq.adr = VRAM_BASE + 16'(ofs);
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         state      <= ST_IDLE;
         ofs        <= '0;
         left       <= 6'd0;
         scan_valid <= 1'b0;
      end else begin
         scan_valid <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (start_pulse) begin
                  ofs   <= OFS_W'(page * PAGE_BYTES);   // page wraps in vram
                  left  <= LINE_LEN[mode];
                  state <= ST_FETCH;
               end
            end
            ST_FETCH: begin
               if (fetch_ack) begin
                  scan_valid <= 1'b1;
                  ofs        <= ofs + 1'b1;
                  left       <= left - 1'b1;
                  if (last_byte) begin
                     state <= ST_LAST;                 // let final byte out
                  end
               end
            end
            ST_LAST: state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (fetch_ack) begin
         scan_data <= fetch_dat;
      end
   end

   a_start_when_idle: assert property (
      @(posedge sys_clk) disable iff (!reset_n)
      start_pulse |-> !busy
   ) else $error("start_pulse while a line is running");

endmodule

`default_nettype wire

/* src/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
   input  logic                  sys_clk,
   input  logic                  reset_n,
   input  compy_pkg::wb_req_t    wb_in,
   output compy_pkg::wb_rsp_t    wb_out,
   input  compy_pkg::fetch_req_t freq,
   output logic                  fetch_ack,
   output logic [7:0]            fetch_dat,
   output logic [15:0]           mem_adr,
   output logic                  mem_we,
   output logic [7:0]            mem_wdata,
   output logic                  sel_ram,
   output logic                  sel_vram,
   output logic                  sel_rom,
   output logic                  sel_vregs,
   input  logic [7:0]            rdata_ram,
   input  logic [7:0]            rdata_vram,
   input  logic [7:0]            rdata_rom,
   input  logic [7:0]            rdata_vregs
);
   import compy_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_GRANT,
      ST_ACK
   } state_t;

   state_t      state;
   logic        last_fetch;                  // fetch owns the current or last slot
   logic        cpu_pend;
   logic        fetch_pend;
   logic        take_cpu;
   logic        take_fetch;
   logic        in_grant;
   logic [15:0] a_adr;
   logic        a_we;
   logic [7:0]  a_wdata;
   region_t     region;
   region_t     r_region;
   logic [7:0]  rd_mux;

   assign cpu_pend   = wb_in.cyc && wb_in.stb;
   assign fetch_pend = freq.req;
   assign in_grant   = (state == ST_GRANT);

   addr_decode u_decode (
      .adr    (a_adr),
      .region (region),
      .offset (mem_adr)
   );

   // winner selection; the ack cycle hands over only to the other master
   always_comb begin
      take_cpu   = 1'b0;
      take_fetch = 1'b0;
      case (state)
         ST_IDLE: begin
            if (cpu_pend && fetch_pend) begin
               take_cpu   = last_fetch;
               take_fetch = !last_fetch;
            end else begin
               take_cpu   = cpu_pend;
               take_fetch = fetch_pend;
            end
         end
         ST_ACK: begin
            take_cpu   = last_fetch && cpu_pend;
            take_fetch = !last_fetch && fetch_pend;
         end
         default: ;
      endcase
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         state      <= ST_IDLE;
         last_fetch <= 1'b0;
         r_region   <= REG_NONE;
      end else begin
         case (state)
            ST_GRANT: begin
               r_region <= region;            // steers the read mux next cycle
               state    <= ST_ACK;
            end
            default: begin
               if (take_cpu || take_fetch) begin
                  last_fetch <= take_fetch;
                  state      <= ST_GRANT;
               end else begin
                  state <= ST_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (take_cpu || take_fetch) begin
         a_adr   <= take_fetch ? freq.adr : wb_in.adr;
         a_we    <= take_cpu && wb_in.we;     // fetch never writes
         a_wdata <= wb_in.dat;
      end
   end

   assign sel_ram   = in_grant && (region == REG_RAM);
   assign sel_vram  = in_grant && (region == REG_VRAM);
   assign sel_rom   = in_grant && (region == REG_ROM);
   assign sel_vregs = in_grant && (region == REG_VREGS);
   assign mem_we    = in_grant && a_we && (region != REG_ROM);
   assign mem_wdata = a_wdata;

   always_comb begin
      case (r_region)
         REG_RAM:   rd_mux = rdata_ram;
         REG_VRAM:  rd_mux = rdata_vram;
         REG_ROM:   rd_mux = rdata_rom;
         REG_VREGS: rd_mux = rdata_vregs;
         default:   rd_mux = UNMAPPED_DATA;
      endcase
      wb_out.ack = (state == ST_ACK) && !last_fetch;
      wb_out.dat = rd_mux;
      fetch_ack  = (state == ST_ACK) && last_fetch;
      fetch_dat  = rd_mux;
   end

   a_fetch_ack_with_req: assert property (
      @(posedge sys_clk) disable iff (!reset_n)
      fetch_ack |-> freq.req
   ) else $error("fetch ack without a pending request");

   a_ack_with_stb: assert property (
      @(posedge sys_clk) disable iff (!reset_n)
      wb_out.ack |-> wb_in.stb
   ) else $error("wishbone ack without stb");

endmodule

`default_nettype wire

/* src/compy_core.sv */
`timescale 1ns/1ps
`default_nettype none

module compy_core (
   input  logic               sys_clk,
   input  logic               reset_n,
   input  compy_pkg::wb_req_t wb_in,
   output compy_pkg::wb_rsp_t wb_out,
   output logic [7:0]         scan_data,
   output logic               scan_valid,
   output logic               video_busy
);
   import compy_pkg::*;

   fetch_req_t  freq;
   logic        fetch_ack;
   logic [7:0]  fetch_dat;
   logic [15:0] mem_adr;
   logic        mem_we;
   logic [7:0]  mem_wdata;
   logic        sel_ram;
   logic        sel_vram;
   logic        sel_rom;
   logic        sel_vregs;
   logic [7:0]  rdata_ram;
   logic [7:0]  rdata_vram;
   logic [7:0]  rdata_rom;
   logic [7:0]  rdata_vregs;
   logic        start_pulse;
   logic [1:0]  mode;
   logic [7:0]  page;

   bus_arbiter u_arbiter (
      .sys_clk     (sys_clk),
      .reset_n     (reset_n),
      .wb_in       (wb_in),
      .wb_out      (wb_out),
      .freq        (freq),
      .fetch_ack   (fetch_ack),
      .fetch_dat   (fetch_dat),
      .mem_adr     (mem_adr),
      .mem_we      (mem_we),
      .mem_wdata   (mem_wdata),
      .sel_ram     (sel_ram),
      .sel_vram    (sel_vram),
      .sel_rom     (sel_rom),
      .sel_vregs   (sel_vregs),
      .rdata_ram   (rdata_ram),
      .rdata_vram  (rdata_vram),
      .rdata_rom   (rdata_rom),
      .rdata_vregs (rdata_vregs)
   );

   ram_block #(.DEPTH(RAM_DEPTH)) u_work_ram (
      .sys_clk (sys_clk),
      .sel     (sel_ram),
      .we      (mem_we),
      .adr     (mem_adr),
      .wdata   (mem_wdata),
      .rdata   (rdata_ram)
   );

   ram_block #(.DEPTH(VRAM_DEPTH)) u_video_ram (
      .sys_clk (sys_clk),
      .sel     (sel_vram),
      .we      (mem_we),
      .adr     (mem_adr),
      .wdata   (mem_wdata),
      .rdata   (rdata_vram)
   );

   char_rom u_char_rom (
      .sys_clk (sys_clk),
      .sel     (sel_rom),
      .adr     (mem_adr[10:0]),
      .rdata   (rdata_rom)
   );

   video_regs u_video_regs (
      .sys_clk     (sys_clk),
      .reset_n     (reset_n),
      .sel         (sel_vregs),
      .we          (mem_we),
      .adr         (mem_adr[7:0]),
      .wdata       (mem_wdata),
      .rdata       (rdata_vregs),
      .busy        (video_busy),
      .start_pulse (start_pulse),
      .mode        (mode),
      .page        (page)
   );

   video_fetch u_video_fetch (
      .sys_clk     (sys_clk),
      .reset_n     (reset_n),
      .start_pulse (start_pulse),
      .mode        (mode),
      .page        (page),
      .freq        (freq),
      .fetch_ack   (fetch_ack),
      .fetch_dat   (fetch_dat),
      .busy        (video_busy),
      .scan_data   (scan_data),
      .scan_valid  (scan_valid)
   );

endmodule

`default_nettype wire

/* test/compy_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module compy_tb;
   import compy_pkg::*;

   typedef enum logic [1:0] {
      OP_WRITE,
      OP_READ,
      OP_START,
      OP_WAIT
   } op_t;

   typedef struct packed {
      op_t         op;
      logic [15:0] adr;
      logic [7:0]  dat;                      // write data, or line length for OP_WAIT
      logic [7:0]  exp;
   } entry_t;

   localparam int ACK_LIMIT  = 20;
   localparam int LINE_LIMIT = 400;

   logic       sys_clk;
   logic       reset_n;
   wb_req_t    wb_in;
   wb_rsp_t    wb_out;
   logic [7:0] scan_data;
   logic       scan_valid;
   logic       video_busy;

   entry_t     table_q [$];
   logic [7:0] shadow_ram [4096];
   logic [7:0] shadow_vram [2048];
   logic [7:0] exp_scan [$];
   logic [7:0] got_scan [$];
   integer     seed = 11607;
   int         checks = 0;
   int         mismatches = 0;
   int         others = 0;
   logic       table_ready = 1'b0;

   compy_core i_dut (
      .sys_clk    (sys_clk),
      .reset_n    (reset_n),
      .wb_in      (wb_in),
      .wb_out     (wb_out),
      .scan_data  (scan_data),
      .scan_valid (scan_valid),
      .video_busy (video_busy)
   );

   initial begin
      sys_clk = 1'b0;
      forever #2 sys_clk = ~sys_clk;
   end

   // scan stream collector
   initial begin
      forever begin
         @(negedge sys_clk);
         if (reset_n && scan_valid) got_scan.push_back(scan_data);
      end
   end

   function automatic int line_len(input logic [1:0] mode);
      case (mode)
         2'd1:    return 20;
         2'd2:    return 32;
         default: return 16;                 // modes 0 and 3
      endcase
   endfunction

   // expected read data for ram, vram, rom and unmapped space
   function automatic logic [7:0] model_read(input logic [15:0] adr);
      logic [15:0] off;
      if (adr <= 16'h8FFF) return shadow_ram[adr[11:0]];
      if (adr >= 16'hA000 && adr <= 16'hDFFF) begin
         off = adr - 16'hA000;
         return shadow_vram[off[10:0]];
      end
      if (adr >= 16'hE000) begin
         off = adr - 16'hE000;
         return off[7:0] ^ 8'h5A;
      end
      return 8'hFF;
   endfunction

   task automatic add_entry(input op_t op, input logic [15:0] adr,
                            input logic [7:0] dat, input logic [7:0] exp);
      entry_t e;
      e.op  = op;
      e.adr = adr;
      e.dat = dat;
      e.exp = exp;
      table_q.push_back(e);
   endtask

   task automatic add_write(input logic [15:0] adr, input logic [7:0] dat);
      logic [15:0] off;
      off = adr - 16'hA000;
      if (adr <= 16'h8FFF) shadow_ram[adr[11:0]] = dat;
      else if (adr >= 16'hA000 && adr <= 16'hDFFF) shadow_vram[off[10:0]] = dat;
      add_entry(OP_WRITE, adr, dat, 8'h00);
   endtask

   task automatic add_read(input logic [15:0] adr, input logic [7:0] exp);
      add_entry(OP_READ, adr, 8'h00, exp);
   endtask

   // one scan line with cpu traffic while it runs
   task automatic add_line(input logic [1:0] mode, input logic [7:0] page);
      int          n;
      integer      rnd;
      logic [15:0] a;
      n = line_len(mode);
      for (int k = 0; k < n; k++) begin
         exp_scan.push_back(shadow_vram[(int'(page) * 512 + k) % 2048]);
      end
      add_write(16'h9001, page);
      add_entry(OP_START, 16'h9000, {5'd0, mode, 1'b1}, 8'h00);
      add_read(16'h9002, 8'h01);             // busy while the line runs
      add_write(16'h9000, {5'd0, mode, 1'b1});   // start while busy, no effect
      for (int k = 0; k < 2; k++) begin
         a   = 16'h0800 + 16'(page) * 16'd8 + 16'(k);
         rnd = $random(seed);
         add_write(a, rnd[7:0]);
         add_read(a, model_read(a));
      end
      add_entry(OP_WAIT, 16'h0000, 8'(n), 8'h00);
      add_read(16'h9002, 8'h00);
      add_read(16'h9000, {5'd0, mode, 1'b0});
      add_read(16'h9001, page);
   endtask

   task automatic build_table;
      integer      rnd;
      logic [15:0] a;
      add_read(16'h9000, 8'h00);                    // mode 0 out of reset
      add_read(16'h9001, 8'h00);
      for (int i = 0; i < 6; i++) begin
         a   = 16'h0100 + 16'(i) * 16'h0155;
         rnd = $random(seed);
         add_write(a, rnd[7:0]);
         add_read(a, model_read(a));
         add_read(a + 16'h1000, model_read(a));     // aliases every 4 KB
      end
      add_write(16'h5234, 8'hC3);
      add_read(16'h0234, model_read(16'h0234));
      add_write(16'h8FFF, 8'h3C);
      add_read(16'h0FFF, model_read(16'h0FFF));
      add_read(16'hE000, model_read(16'hE000));
      add_read(16'hE0A5, model_read(16'hE0A5));
      add_read(16'hE7FF, model_read(16'hE7FF));
      add_read(16'hF123, model_read(16'hF123));
      add_write(16'hE010, 8'h00);                   // rom ignores writes
      add_read(16'hE010, model_read(16'hE010));
      add_write(16'h9001, 8'h07);
      add_read(16'h9001, 8'h07);
      add_write(16'h9000, 8'h06);                   // mode 3, no start
      add_read(16'h9000, 8'h06);
      add_read(16'h9002, 8'h00);
      add_read(16'h9005, 8'h00);
      add_read(16'h9080, 8'hFF);
      add_read(16'h9FFF, 8'hFF);
      add_write(16'h9100, 8'h55);
      add_read(16'h9100, 8'hFF);
      foreach (shadow_vram[j]) begin
         if (j / 512 != 2 && j % 512 < 32) begin    // pages 0, 1 and 3
            rnd = $random(seed);
            add_write(16'hA000 + 16'(j), rnd[7:0]);
         end
      end
      add_read(16'hA61F, model_read(16'hA61F));
      add_read(16'hC005, model_read(16'hC005));     // vram alias of page 0
      add_line(2'd0, 8'd0);
      add_line(2'd1, 8'd5);                         // page 5 wraps to 1
      add_line(2'd2, 8'd3);
   endtask

   // single wishbone classic cycle, starts and ends on a falling edge
   task automatic wb_access(input logic we, input logic [15:0] adr, input logic [7:0] dat,
                            output logic [7:0] rdat, output int lat);
      int   n;
      logic got;
      n         = 0;
      got       = 1'b0;
      wb_in.cyc = 1'b1;
      wb_in.stb = 1'b1;
      wb_in.we  = we;
      wb_in.adr = adr;
      wb_in.dat = dat;
      while (!got && n < ACK_LIMIT) begin
         @(negedge sys_clk);
         n++;
         if (wb_out.ack) got = 1'b1;
      end
      rdat = wb_out.dat;
      lat  = n;
      assert (got) else begin
         $display("ERROR: no ack from address %h within %0d cycles", adr, ACK_LIMIT);
         others++;
      end
      @(posedge sys_clk);                    // edge that samples ack
      @(negedge sys_clk);
      wb_in = '0;
   endtask

   task automatic check_latency(input logic [15:0] adr, input logic idle, input int lat);
      assert (lat <= 4) else begin
         $display("ERROR: access to %h took %0d cycles, more than 4", adr, lat);
         others++;
      end
      assert (!idle || lat == 2) else begin
         $display("ERROR: idle access to %h took %0d cycles instead of 2", adr, lat);
         others++;
      end
   endtask

   task automatic check_line(input int n);
      int         cycles;
      logic [7:0] exp_b;
      cycles = 0;
      while (video_busy && cycles < LINE_LIMIT) begin
         @(negedge sys_clk);
         cycles++;
      end
      assert (!video_busy) else begin
         $display("ERROR: video fetch still busy after %0d cycles", LINE_LIMIT);
         others++;
      end
      checks++;
      assert (got_scan.size() == n) else begin
         $display("MISMATCH scan byte count: got %h expected %h", got_scan.size(), n);
         mismatches++;
      end
      for (int i = 0; i < n; i++) begin
         exp_b = exp_scan.pop_front();
         if (i < got_scan.size()) begin
            checks++;
            assert (got_scan[i] === exp_b) else begin
               $display("MISMATCH scan_data byte %h: got %h expected %h",
                        i, got_scan[i], exp_b);
               mismatches++;
            end
         end
      end
      got_scan.delete();
   endtask

   task automatic print_summary;
      $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, others);
   endtask

   initial begin
      int limit;
      wait (table_ready === 1'b1);
      limit = table_q.size() * 40 + 3 * 32 * 8;
      repeat (limit) @(posedge sys_clk);
      $display("ERROR: watchdog expired after %0d cycles", limit);
      others++;
      print_summary();
      $display("*** FAILED ***");
      $finish;
   end

   initial begin
      entry_t     e;
      logic [7:0] rdat;
      int         lat;
      logic       idle;
      wb_in   = '0;
      reset_n = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (8) @(posedge sys_clk);
      @(negedge sys_clk);
      reset_n = 1'b1;
      checks++;
      assert (!wb_out.ack && !scan_valid && !video_busy) else begin
         $display("ERROR: ack, scan_valid or busy high after reset");
         others++;
      end
      for (int i = 0; i < table_q.size(); i++) begin
         e    = table_q[i];
         idle = !video_busy;
         case (e.op)
            OP_WAIT: check_line(int'(e.dat));
            OP_READ: begin
               wb_access(1'b0, e.adr, 8'h00, rdat, lat);
               check_latency(e.adr, idle, lat);
               checks++;
               assert (rdat === e.exp) else begin
                  $display("MISMATCH wb_out.dat at %h: got %h expected %h", e.adr, rdat, e.exp);
                  mismatches++;
               end
            end
            default: begin
               wb_access(1'b1, e.adr, e.dat, rdat, lat);
               check_latency(e.adr, idle, lat);
            end
         endcase
      end
      print_summary();
      if (mismatches + others == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
src/compy_pkg.sv
src/addr_decode.sv
src/char_rom.sv
src/ram_block.sv
src/video_regs.sv
src/video_fetch.sv
src/bus_arbiter.sv
src/compy_core.sv
test/compy_tb.sv
